// ==== common/aud_dsp_pkg.sv ====
// audio dsp control plane definitions
`default_nettype none

package aud_dsp_pkg;

    // ----------------------------------------
    // field widths, all set by the register map
    localparam int OP_W     = 6;   // operation code
    localparam int QBITS_W  = 6;   // quant bit count
    localparam int OFFSET_W = 8;   // register buffer offsets
    localparam int PARAM_W  = 32;  // op parameter word
    localparam int BUF_AW   = 9;   // engine buffer address
    localparam int TAB_AW   = 10;  // coefficient table address

    // interrupt vector bit positions
    localparam int INTR_FRAME    = 0;  // audio frame ready
    localparam int INTR_DSP_DONE = 1;  // dsp done

    // ----------------------------------------
    typedef enum logic [OP_W-1:0] {
        OP_HAM_WIN = 6'h00,  // hamming window
        OP_CABS    = 6'h02,  // complex abs
        OP_LN      = 6'h03,
        OP_MFCC    = 6'h04,  // abs + mel map + ln
        OP_FFT     = 6'h20,
        OP_IFFT    = 6'h21,
        OP_FEATURE = 6'h30   // ham win then fft then mfcc
    } dsp_op_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_HAM,
        SEQ_FFT,
        SEQ_MFCC
    } seq_state_e;

    // one software command
    typedef struct packed {
        dsp_op_e               op;
        logic                  in_buf_sel_mode;  // low takes previous result buffer
        logic                  in_buf_sel;       // high reads buffer b
        logic [QBITS_W-1:0]    in_quant_bits;
        logic [OFFSET_W-1:0]   in_buf_offset;
        logic [OFFSET_W-1:0]   out_buf_offset;
        logic [OFFSET_W-1:0]   coef_buf_offset;
        logic [PARAM_W-1:0]    param0;
    } dsp_cmd_t;

    // held for the fft engine
    typedef struct packed {
        logic                  ifft_en;
        logic                  quant_input_en;  // drop 1 bit before first round
        logic [3:0]            fft_n;           // 2^fft_n points
        logic [BUF_AW-1:0]     in_buf_offset;
        logic [BUF_AW-1:0]     out_buf_offset;
        logic                  in_buf_sel_mode;
        logic                  in_buf_sel;
    } fft_req_t;

    // held for the vector engine
    typedef struct packed {
        logic [4:0]            op;
        logic                  in_buf_sel_mode;
        logic                  in_buf_sel;
        logic [QBITS_W-1:0]    in_quant_bits;
        logic [TAB_AW-1:0]     tab_offset;
        logic [BUF_AW-1:0]     vector_len;
        logic [BUF_AW-1:0]     in_vector_start;
        logic [BUF_AW-1:0]     out_vector_start;
    } vec_req_t;

    // reported back by each engine
    typedef struct packed {
        logic                  busy;
        logic [QBITS_W-1:0]    out_quant_bits;  // valid when busy falls
        logic                  result_in;       // buffer holding the result
    } engine_status_t;

endpackage

`default_nettype wire

// ==== hdl/pulse_sync.sv ====
// async pulse synchronizer
`default_nettype none

module pulse_sync (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic pulse_i,  // async, at least one cycle wide
    output logic      pulse_o   // one cycle, clk domain
);

    logic [1:0] sync_q;  // metastability stages
    logic       hist_q;  // synchronized level, one cycle late

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q  <= '0;
            hist_q  <= 1'b0;
            pulse_o <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], pulse_i};
            hist_q  <= sync_q[1];
            // rising edge of the synchronized level
            pulse_o <= sync_q[1] & ~hist_q;
        end
    end

endmodule

`default_nettype wire

// ==== dispatch/op_dispatch.sv ====
// command decode and engine dispatch
`default_nettype none

module op_dispatch (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   start_i,      // synchronized software start
    input  wire aud_dsp_pkg::dsp_cmd_t  cmd_i,        // register command
    input  wire logic                   seq_start_i,  // step start from sequencer
    input  wire aud_dsp_pkg::dsp_cmd_t  seq_cmd_i,
    input  wire logic                   seq_busy_i,
    output logic                        seq_go_o,     // kicks feature sequencer
    output logic                        fft_start_o,
    output aud_dsp_pkg::fft_req_t       fft_req_o,
    output logic                        vec_start_o,
    output aud_dsp_pkg::vec_req_t       vec_req_o
);

    aud_dsp_pkg::dsp_cmd_t cmd_sel;
    aud_dsp_pkg::fft_req_t fft_req_d;
    aud_dsp_pkg::vec_req_t vec_req_d;
    logic                  start_sel;
    logic                  is_fft;
    logic                  is_vec;
    logic                  is_seq;

    // ----------------------------------------
    // sequencer owns the command while it runs
    assign cmd_sel   = seq_busy_i ? seq_cmd_i : cmd_i;
    assign start_sel = seq_busy_i ? seq_start_i : start_i;

    // target from the top op bits
    assign is_fft = start_sel && (cmd_sel.op[5:4] == 2'b10);  // 0x2x
    assign is_vec = start_sel && !cmd_sel.op[5];              // 0x0x and 0x1x
    assign is_seq = start_sel && (cmd_sel.op[5:4] == 2'b11);  // 0x3x group

    // ----------------------------------------
    // request field mapping
    always_comb begin
        fft_req_d.ifft_en         = cmd_sel.op[0];
        fft_req_d.quant_input_en  = cmd_sel.param0[4];
        fft_req_d.fft_n           = cmd_sel.param0[3:0];
        fft_req_d.in_buf_offset   = {cmd_sel.in_buf_offset, 1'b0};   // x2
        fft_req_d.out_buf_offset  = {cmd_sel.out_buf_offset, 1'b0};
        fft_req_d.in_buf_sel_mode = cmd_sel.in_buf_sel_mode;
        fft_req_d.in_buf_sel      = cmd_sel.in_buf_sel;

        vec_req_d.op               = cmd_sel.op[4:0];  // bit 5 always clear here
        vec_req_d.in_buf_sel_mode  = cmd_sel.in_buf_sel_mode;
        vec_req_d.in_buf_sel       = cmd_sel.in_buf_sel;
        vec_req_d.in_quant_bits    = cmd_sel.in_quant_bits;
        // table is 8 words per coef step
        vec_req_d.tab_offset       = {cmd_sel.coef_buf_offset[aud_dsp_pkg::TAB_AW-4:0], 3'b000};
        vec_req_d.vector_len       = cmd_sel.param0[aud_dsp_pkg::BUF_AW-1:0];
        // vector starts in units of 4 words
        vec_req_d.in_vector_start  = {cmd_sel.in_buf_offset[aud_dsp_pkg::BUF_AW-3:0], 2'b00};
        vec_req_d.out_vector_start = {cmd_sel.out_buf_offset[aud_dsp_pkg::BUF_AW-3:0], 2'b00};
    end

    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fft_start_o <= 1'b0;
            vec_start_o <= 1'b0;
            seq_go_o    <= 1'b0;
        end else begin
            fft_start_o <= is_fft;
            vec_start_o <= is_vec;
            seq_go_o    <= is_seq;
        end
    end

    // requests held until the same engine starts again
    always_ff @(posedge clk) begin
        if (is_fft) begin
            fft_req_o <= fft_req_d;
        end
        if (is_vec) begin
            vec_req_o <= vec_req_d;
        end
    end

    // software must wait for the sequencer to drain
    assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> !seq_busy_i && !seq_go_o)
        else $error("software start while sequencer busy");

endmodule

`default_nettype wire

// ==== dispatch/feature_seq.sv ====
// feature extract sequencer
`default_nettype none

module feature_seq (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   go_i,        // op 0x30 decoded
    input  wire aud_dsp_pkg::dsp_cmd_t  cmd_i,
    input  wire logic                   fft_done_i,
    input  wire logic                   vec_done_i,
    output logic                        seq_start_o, // one pulse per step
    output aud_dsp_pkg::dsp_cmd_t       seq_cmd_o,
    output logic                        seq_busy_o
);

    aud_dsp_pkg::seq_state_e state_q;
    aud_dsp_pkg::seq_state_e state_d;
    aud_dsp_pkg::dsp_cmd_t   cmd_q;    // command as seen at go
    logic                    start_d;

    // ----------------------------------------
    // ham -> fft -> mfcc, each on previous done
    always_comb begin
        state_d = state_q;
        start_d = 1'b0;
        case (state_q)
            aud_dsp_pkg::SEQ_IDLE: begin
                if (go_i) begin
                    state_d = aud_dsp_pkg::SEQ_HAM;
                    start_d = 1'b1;
                end
            end
            aud_dsp_pkg::SEQ_HAM: begin
                if (vec_done_i) begin  // window written
                    state_d = aud_dsp_pkg::SEQ_FFT;
                    start_d = 1'b1;
                end
            end
            aud_dsp_pkg::SEQ_FFT: begin
                if (fft_done_i) begin
                    state_d = aud_dsp_pkg::SEQ_MFCC;
                    start_d = 1'b1;
                end
            end
            aud_dsp_pkg::SEQ_MFCC: begin
                if (vec_done_i) begin
                    state_d = aud_dsp_pkg::SEQ_IDLE;  // whole chain done
                end
            end
            default: state_d = aud_dsp_pkg::SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= aud_dsp_pkg::SEQ_IDLE;
            seq_start_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            seq_start_o <= start_d;
        end
    end

    always_ff @(posedge clk) begin
        if (go_i) begin
            cmd_q <= cmd_i;
        end
    end

    // ----------------------------------------
    // step command, later steps chain on previous result
    always_comb begin
        seq_cmd_o = cmd_q;
        case (state_q)
            aud_dsp_pkg::SEQ_FFT: begin
                seq_cmd_o.op              = aud_dsp_pkg::OP_FFT;
                seq_cmd_o.in_buf_sel_mode = 1'b0;
            end
            aud_dsp_pkg::SEQ_MFCC: begin
                seq_cmd_o.op              = aud_dsp_pkg::OP_MFCC;
                seq_cmd_o.in_buf_sel_mode = 1'b0;
            end
            default: seq_cmd_o.op = aud_dsp_pkg::OP_HAM_WIN;  // keeps register buf select
        endcase
    end

    assign seq_busy_o = go_i || (state_q != aud_dsp_pkg::SEQ_IDLE);

    // only the engine of the running step may finish
    assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == aud_dsp_pkg::SEQ_FFT) |-> !vec_done_i)
        else $error("vector done during fft step");
    assert property (@(posedge clk) disable iff (!rst_n)
        (state_q inside {aud_dsp_pkg::SEQ_HAM, aud_dsp_pkg::SEQ_MFCC}) |-> !fft_done_i)
        else $error("fft done during vector step");

endmodule

`default_nettype wire

// ==== hdl/engine_monitor.sv ====
// engine completion and result tracking
`default_nettype none

module engine_monitor (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire aud_dsp_pkg::engine_status_t  fft_status_i,
    input  wire aud_dsp_pkg::engine_status_t  vec_status_i,
    input  wire logic                         seq_busy_i,
    output logic                              fft_done_o,
    output logic                              vec_done_o,
    output logic                              busy_o,
    output logic                              dsp_done_o,  // one cycle after busy falls
    output logic                              result_in_o,
    output logic [aud_dsp_pkg::QBITS_W-1:0]   out_quant_bits_o
);

    logic                            fft_busy_q;
    logic                            vec_busy_q;
    logic                            busy_q;
    logic [aud_dsp_pkg::QBITS_W-1:0] qbits_q;   // last captured result info
    logic                            result_q;

    // falling edges of engine busy
    assign fft_done_o = fft_busy_q & ~fft_status_i.busy;
    assign vec_done_o = vec_busy_q & ~vec_status_i.busy;
    assign busy_o     = fft_status_i.busy | vec_status_i.busy | seq_busy_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fft_busy_q <= 1'b0;
            vec_busy_q <= 1'b0;
            busy_q     <= 1'b0;
            dsp_done_o <= 1'b0;
        end else begin
            fft_busy_q <= fft_status_i.busy;
            vec_busy_q <= vec_status_i.busy;
            busy_q     <= busy_o;
            dsp_done_o <= busy_q & ~busy_o;
        end
    end

    // ----------------------------------------
    // capture, fft first on a tie
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            qbits_q  <= '0;
            result_q <= 1'b0;
        end else if (fft_done_o) begin
            qbits_q  <= fft_status_i.out_quant_bits;
            result_q <= fft_status_i.result_in;
        end else if (vec_done_o) begin
            qbits_q  <= vec_status_i.out_quant_bits;
            result_q <= vec_status_i.result_in;
        end
    end

    // bypass so the next step sees the new value at once
    always_comb begin
        if (fft_done_o) begin
            out_quant_bits_o = fft_status_i.out_quant_bits;
            result_in_o      = fft_status_i.result_in;
        end else if (vec_done_o) begin
            out_quant_bits_o = vec_status_i.out_quant_bits;
            result_in_o      = vec_status_i.result_in;
        end else begin
            out_quant_bits_o = qbits_q;
            result_in_o      = result_q;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/intr_ctrl.sv ====
// interrupt status and line
`default_nettype none

module intr_ctrl (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       frame_i,        // frame ready pulse
    input  wire logic       dsp_done_i,
    input  wire logic [1:0] intr_mask_i,    // 1 enables the bit
    input  wire logic [1:0] clr_intr_i,     // pulse per bit
    output logic      [1:0] intr_status_o,
    output logic            intr_o
);

    logic [1:0] event_w;

    assign event_w[aud_dsp_pkg::INTR_FRAME]    = frame_i;
    assign event_w[aud_dsp_pkg::INTR_DSP_DONE] = dsp_done_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            intr_status_o <= '0;
            intr_o        <= 1'b0;
        end else begin
            // a new event beats a clear in the same cycle
            intr_status_o <= event_w | (intr_status_o & ~clr_intr_i);
            intr_o        <= |(intr_status_o & intr_mask_i);  // masked or
        end
    end

endmodule

`default_nettype wire

// ==== hdl/aud_dsp_ctrl_top.sv ====
// audio dsp control plane top
`default_nettype none

module aud_dsp_ctrl_top (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    // software side
    input  wire logic                         start_i,        // async start
    input  wire aud_dsp_pkg::dsp_cmd_t        cmd_i,
    input  wire logic                         frame_ready_i,  // async, from front end
    input  wire logic [1:0]                   intr_mask_i,
    input  wire logic [1:0]                   clr_intr_i,
    // engines
    output logic                              fft_start_o,
    output aud_dsp_pkg::fft_req_t             fft_req_o,
    input  wire aud_dsp_pkg::engine_status_t  fft_status_i,
    output logic                              vec_start_o,
    output aud_dsp_pkg::vec_req_t             vec_req_o,
    input  wire aud_dsp_pkg::engine_status_t  vec_status_i,
    // status
    output logic                              busy_o,
    output logic                              result_in_o,    // also previous result to engines
    output logic [aud_dsp_pkg::QBITS_W-1:0]   out_quant_bits_o,
    output logic [1:0]                        intr_status_o,
    output logic                              intr_o
);

    logic                  start_p;
    logic                  frame_p;
    logic                  seq_go;
    logic                  seq_start;
    logic                  seq_busy;
    aud_dsp_pkg::dsp_cmd_t seq_cmd;
    logic                  fft_done;
    logic                  vec_done;
    logic                  dsp_done;

    // ----------------------------------------
    pulse_sync start_sync_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .pulse_i (start_i),
        .pulse_o (start_p)
    );

    pulse_sync frame_sync_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .pulse_i (frame_ready_i),
        .pulse_o (frame_p)
    );

    op_dispatch op_dispatch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_p),
        .cmd_i       (cmd_i),
        .seq_start_i (seq_start),
        .seq_cmd_i   (seq_cmd),
        .seq_busy_i  (seq_busy),
        .seq_go_o    (seq_go),
        .fft_start_o (fft_start_o),
        .fft_req_o   (fft_req_o),
        .vec_start_o (vec_start_o),
        .vec_req_o   (vec_req_o)
    );

    feature_seq feature_seq_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .go_i        (seq_go),
        .cmd_i       (cmd_i),
        .fft_done_i  (fft_done),
        .vec_done_i  (vec_done),
        .seq_start_o (seq_start),
        .seq_cmd_o   (seq_cmd),
        .seq_busy_o  (seq_busy)
    );

    // ----------------------------------------
    engine_monitor engine_monitor_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .fft_status_i     (fft_status_i),
        .vec_status_i     (vec_status_i),
        .seq_busy_i       (seq_busy),
        .fft_done_o       (fft_done),
        .vec_done_o       (vec_done),
        .busy_o           (busy_o),
        .dsp_done_o       (dsp_done),
        .result_in_o      (result_in_o),
        .out_quant_bits_o (out_quant_bits_o)
    );

    intr_ctrl intr_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .frame_i       (frame_p),
        .dsp_done_i    (dsp_done),
        .intr_mask_i   (intr_mask_i),
        .clr_intr_i    (clr_intr_i),
        .intr_status_o (intr_status_o),
        .intr_o        (intr_o)
    );

endmodule

`default_nettype wire

// ==== bench/tb_aud_dsp_ctrl.sv ====
// audio dsp control plane testbench
`default_nettype none

module tb_aud_dsp_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    logic                         clk = 1'b0;
    logic                         rst_n = 1'b0;
    logic                         start_i = 1'b0;
    aud_dsp_pkg::dsp_cmd_t        cmd_i = '0;
    logic                         frame_ready_i = 1'b0;
    logic [1:0]                   intr_mask_i = 2'b00;
    logic [1:0]                   clr_intr_i = 2'b00;
    aud_dsp_pkg::engine_status_t  fft_status = '0;   // driven by engine models
    aud_dsp_pkg::engine_status_t  vec_status = '0;
    logic                         fft_start_o;
    logic                         vec_start_o;
    aud_dsp_pkg::fft_req_t        fft_req_o;
    aud_dsp_pkg::vec_req_t        vec_req_o;
    logic                         busy_o;
    logic                         result_in_o;
    logic [5:0]                   out_quant_bits_o;
    logic [1:0]                   intr_status_o;
    logic                         intr_o;

    integer                       seed = 32'h41c4_93d8;
    aud_dsp_pkg::fft_req_t        fft_log[$];   // requests seen by the engines
    aud_dsp_pkg::vec_req_t        vec_log[$];
    logic                         order_log[$]; // 1 fft, 0 vector
    int                           fft_cnt;
    int                           vec_cnt;
    logic [5:0]                   last_qbits = '0;  // last reported by any engine
    logic                         last_res = 1'b0;
    logic                         have_result = 1'b0;
    logic                         st1_q = 1'b0;
    int                           done_irq_cnt = 0;
    int                           err_cnt = 0;
    int                           test_err0 = 0;
    int                           n_tests = 0;
    int                           n_bad = 0;

    aud_dsp_ctrl_top dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .start_i          (start_i),
        .cmd_i            (cmd_i),
        .frame_ready_i    (frame_ready_i),
        .intr_mask_i      (intr_mask_i),
        .clr_intr_i       (clr_intr_i),
        .fft_start_o      (fft_start_o),
        .fft_req_o        (fft_req_o),
        .fft_status_i     (fft_status),
        .vec_start_o      (vec_start_o),
        .vec_req_o        (vec_req_o),
        .vec_status_i     (vec_status),
        .busy_o           (busy_o),
        .result_in_o      (result_in_o),
        .out_quant_bits_o (out_quant_bits_o),
        .intr_status_o    (intr_status_o),
        .intr_o           (intr_o)
    );

    initial begin : clock_gen
        forever #10 clk = ~clk;  // 20 ns period
    end

    // ----------------------------------------
    // engine models, busy 3 to 20 cycles
    always @(posedge clk) begin : fft_engine
        logic [31:0] rnd;
        if (!rst_n) begin
            fft_status <= '0;
            fft_cnt = 0;
        end else if (fft_start_o) begin
            fft_log.push_back(fft_req_o);
            order_log.push_back(1'b1);
            rnd = $random(seed);
            fft_cnt = 3 + int'(rnd[15:0] % 16'd18);
            fft_status.busy <= 1'b1;  // cycle after start
        end else if (fft_status.busy) begin
            fft_cnt = fft_cnt - 1;
            if (fft_cnt == 0) begin
                rnd = $random(seed);
                fft_status  <= '{busy: 1'b0, out_quant_bits: rnd[5:0], result_in: rnd[6]};
                last_qbits  <= rnd[5:0];
                last_res    <= rnd[6];
                have_result <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin : vec_engine
        logic [31:0] rnd;
        if (!rst_n) begin
            vec_status <= '0;
            vec_cnt = 0;
        end else if (vec_start_o) begin
            vec_log.push_back(vec_req_o);
            order_log.push_back(1'b0);
            rnd = $random(seed);
            vec_cnt = 3 + int'(rnd[15:0] % 16'd18);
            vec_status.busy <= 1'b1;
        end else if (vec_status.busy) begin
            vec_cnt = vec_cnt - 1;
            if (vec_cnt == 0) begin
                rnd = $random(seed);
                vec_status  <= '{busy: 1'b0, out_quant_bits: rnd[5:0], result_in: rnd[6]};
                last_qbits  <= rnd[5:0];
                last_res    <= rnd[6];
                have_result <= 1'b1;
            end
        end
    end

    // result info must track the last completion every cycle
    always @(posedge clk) begin : result_watch
        if (rst_n && have_result) begin
            check("result_hold qbits", last_qbits, out_quant_bits_o);
            check("result_hold buffer", last_res, result_in_o);
        end
        if (intr_status_o[1] && !st1_q) begin
            done_irq_cnt++;  // rising edge of dsp done status
        end
        st1_q = intr_status_o[1];
    end

    // ----------------------------------------
    // expected engine requests
    function automatic aud_dsp_pkg::fft_req_t exp_fft_req(input aud_dsp_pkg::dsp_cmd_t c);
        aud_dsp_pkg::fft_req_t r;
        r.ifft_en         = c.op[0];
        r.quant_input_en  = c.param0[4];
        r.fft_n           = c.param0[3:0];
        r.in_buf_offset   = c.in_buf_offset * 9'd2;
        r.out_buf_offset  = c.out_buf_offset * 9'd2;
        r.in_buf_sel_mode = c.in_buf_sel_mode;
        r.in_buf_sel      = c.in_buf_sel;
        return r;
    endfunction

    function automatic aud_dsp_pkg::vec_req_t exp_vec_req(input aud_dsp_pkg::dsp_cmd_t c);
        aud_dsp_pkg::vec_req_t r;
        r.op               = c.op[4:0];
        r.in_buf_sel_mode  = c.in_buf_sel_mode;
        r.in_buf_sel       = c.in_buf_sel;
        r.in_quant_bits    = c.in_quant_bits;
        r.tab_offset       = c.coef_buf_offset * 10'd8;  // wraps at 10 bits
        r.vector_len       = c.param0[8:0];
        r.in_vector_start  = c.in_buf_offset * 9'd4;
        r.out_vector_start = c.out_buf_offset * 9'd4;
        return r;
    endfunction

    function automatic aud_dsp_pkg::dsp_cmd_t make_cmd(input aud_dsp_pkg::dsp_op_e op);
        aud_dsp_pkg::dsp_cmd_t c;
        logic [31:0]           r1;
        r1 = $random(seed);
        c.op              = op;
        c.in_buf_sel_mode = r1[0];
        c.in_buf_sel      = r1[1];
        c.in_quant_bits   = r1[7:2];
        c.in_buf_offset   = r1[15:8];
        c.out_buf_offset  = r1[23:16];
        c.coef_buf_offset = r1[31:24];
        c.param0          = $random(seed);
        return c;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (err_cnt == test_err0) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s had %0d errors", name, err_cnt - test_err0);
            n_bad++;
        end
        test_err0 = err_cnt;
    endtask

    // poll busy or frame status, gives up after limit cycles
    task automatic wait_for(input bit on_frame, input logic level, input int limit,
                            input string what);
        int n;
        n = 0;
        while ((on_frame ? intr_status_o[0] : busy_o) !== level && n < limit) begin
            @(posedge clk);
            n++;
        end
        if ((on_frame ? intr_status_o[0] : busy_o) !== level) begin
            $display("timeout after %0d cycles waiting for %s", limit, what);
            $display("Regression failed");
            $finish;
        end
    endtask

    // software start, then the whole busy window
    task automatic issue(input aud_dsp_pkg::dsp_cmd_t c);
        fft_log.delete();
        vec_log.delete();
        order_log.delete();
        @(posedge clk);
        cmd_i   <= c;
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        wait_for(1'b0, 1'b1, 40, "busy to rise");
        wait_for(1'b0, 1'b0, 300, "busy to fall");
        // busy must cover the whole engine run
        check("busy covers engines", 2'b00, {fft_status.busy, vec_status.busy});
    endtask

    // ----------------------------------------
    task automatic send_direct_op(input aud_dsp_pkg::dsp_op_e op, input string name);
        aud_dsp_pkg::dsp_cmd_t c;
        logic                  to_fft;
        c = make_cmd(op);
        to_fft = (op == aud_dsp_pkg::OP_FFT) || (op == aud_dsp_pkg::OP_IFFT);
        issue(c);
        repeat (4) @(posedge clk);  // no late starts
        check({name, " fft starts"}, to_fft ? 1 : 0, fft_log.size());
        check({name, " vec starts"}, to_fft ? 0 : 1, vec_log.size());
        if (to_fft && fft_log.size() == 1) begin
            check({name, " fft req"}, exp_fft_req(c), fft_log[0]);
        end
        if (!to_fft && vec_log.size() == 1) begin
            check({name, " vec req"}, exp_vec_req(c), vec_log[0]);
        end
        end_test(name);
    endtask

    task automatic chain_feature_steps();
        aud_dsp_pkg::dsp_cmd_t c;
        aud_dsp_pkg::dsp_cmd_t s;
        int                    irq0;
        @(posedge clk);
        clr_intr_i <= 2'b10;  // drop old dsp done status
        @(posedge clk);
        clr_intr_i <= 2'b00;
        irq0 = done_irq_cnt;
        c = make_cmd(aud_dsp_pkg::OP_FEATURE);
        issue(c);
        // busy fell once, so all three steps ran inside one busy window
        check("feature starts in busy", 3, order_log.size());
        repeat (4) @(posedge clk);
        check("feature starts total", 3, order_log.size());
        check("feature dsp done irqs", 1, done_irq_cnt - irq0);
        if (order_log.size() == 3 && fft_log.size() == 1 && vec_log.size() == 2) begin
            check("feature order", 3'b010, {order_log[0], order_log[1], order_log[2]});
            s = c;
            s.op = aud_dsp_pkg::OP_HAM_WIN;
            check("feature step1 req", exp_vec_req(s), vec_log[0]);
            s.op = aud_dsp_pkg::OP_FFT;
            s.in_buf_sel_mode = 1'b0;  // chained on previous result
            check("feature step2 req", exp_fft_req(s), fft_log[0]);
            s.op = aud_dsp_pkg::OP_MFCC;
            check("feature step3 req", exp_vec_req(s), vec_log[1]);
        end
        end_test("feature_extract");
    endtask

    task automatic watch_result_capture();
        issue(make_cmd(aud_dsp_pkg::OP_LN));
        repeat (10) begin
            @(posedge clk);
            check("capture qbits", last_qbits, out_quant_bits_o);
            check("capture buffer", last_res, result_in_o);
        end
        end_test("result_capture");
    endtask

    task automatic exercise_interrupts();
        @(posedge clk);
        intr_mask_i <= 2'b00;
        clr_intr_i  <= 2'b11;
        @(posedge clk);
        clr_intr_i    <= 2'b00;
        frame_ready_i <= 1'b1;
        @(posedge clk);
        frame_ready_i <= 1'b0;
        wait_for(1'b1, 1'b1, 20, "frame status to set");
        repeat (2) @(posedge clk);
        check("intr frame status", 2'b01, intr_status_o);
        check("intr all masked", 0, intr_o);
        intr_mask_i <= 2'b10;
        repeat (2) @(posedge clk);
        check("intr other bit masked", 0, intr_o);
        intr_mask_i <= 2'b01;
        repeat (2) @(posedge clk);
        check("intr unmasked", 1, intr_o);
        // frame pulse lands in intr_ctrl 4 edges after the drive edge
        frame_ready_i <= 1'b1;
        @(posedge clk);
        frame_ready_i <= 1'b0;
        repeat (2) @(posedge clk);
        clr_intr_i <= 2'b01;  // meets the synchronized frame pulse
        @(posedge clk);
        clr_intr_i <= 2'b00;
        @(posedge clk);
        check("intr set beats clear", 1, intr_status_o[0]);
        clr_intr_i <= 2'b01;
        @(posedge clk);
        clr_intr_i <= 2'b00;
        repeat (2) @(posedge clk);
        check("intr cleared", 0, intr_status_o[0]);
        check("intr line low", 0, intr_o);
        end_test("interrupts");
    endtask

    // ----------------------------------------
    initial begin : test_seq
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        check("reset fft start", 0, fft_start_o);
        check("reset vec start", 0, vec_start_o);
        check("reset busy", 0, busy_o);
        check("reset intr status", 0, intr_status_o);
        check("reset intr", 0, intr_o);
        end_test("reset");
        send_direct_op(aud_dsp_pkg::OP_FFT, "direct_fft");
        send_direct_op(aud_dsp_pkg::OP_IFFT, "direct_ifft");
        send_direct_op(aud_dsp_pkg::OP_HAM_WIN, "direct_ham_win");
        send_direct_op(aud_dsp_pkg::OP_CABS, "direct_cabs");
        send_direct_op(aud_dsp_pkg::OP_LN, "direct_ln");
        send_direct_op(aud_dsp_pkg::OP_MFCC, "direct_mfcc");
        chain_feature_steps();
        watch_result_capture();
        exercise_interrupts();
        $display("tests %0d, failing tests %0d, errors %0d", n_tests, n_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
common/aud_dsp_pkg.sv
hdl/pulse_sync.sv
dispatch/op_dispatch.sv
dispatch/feature_seq.sv
hdl/engine_monitor.sv
hdl/intr_ctrl.sv
hdl/aud_dsp_ctrl_top.sv
bench/tb_aud_dsp_ctrl.sv

// ==== Bender.yml ====
package:
  name: aud_dsp_ctrl

sources:
  - common/aud_dsp_pkg.sv
  - hdl/pulse_sync.sv
  - dispatch/op_dispatch.sv
  - dispatch/feature_seq.sv
  - hdl/engine_monitor.sv
  - hdl/intr_ctrl.sv
  - hdl/aud_dsp_ctrl_top.sv
  - target: test
    files:
      - bench/tb_aud_dsp_ctrl.sv
